//--- capture.f
+incdir+verif
hdl/capture_pkg.sv
hdl/source_arbiter.sv
hdl/capture_sequencer.sv
hdl/route_lane.sv
hdl/frame_assembler.sv
hdl/capture_top.sv
verif/capture_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module capture_tb -f capture.f -Mdir obj_dir -o capture_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out="$(./obj_dir/capture_sim)"
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "test passed" <<< "$sim_out"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- verif/capture_tb_table.svh
`ifndef CAPTURE_TB_TABLE_SVH
`define CAPTURE_TB_TABLE_SVH

// one row per record
// ctrl: lower route [1:0], upper route [5:4], source [9:8]
// ctrl_mid: control word applied halfway through the enabled window
// cycles: adc_enable high time, chirp_init on the first of them
// adc_iq, dac_iq: constant samples for the record
// gaps: adc_valid drawn from the lfsr on data cycles
// exp_words: valid words in the record, 0 where adc_valid has gaps
typedef struct packed {
  logic [31:0] ctrl;
  logic [31:0] ctrl_mid;
  int unsigned cycles;
  logic [31:0] adc_iq;
  logic [31:0] dac_iq;
  logic        gaps;
  int unsigned exp_words;
} rec_t;

localparam int NUM_RECS = 8;

// chirp records hold exactly cycles words before padding,
// waveform records 17 fewer (start delay 19, end delay 2)
// then rounded up to a multiple of 64
localparam rec_t RECS [NUM_RECS] = '{
  // chirp, upper dac, lower adc
  '{32'h0000_0010, 32'h0000_0010, 40, 32'h1234_5678, 32'h9abc_def0, 1'b0, 64},
  // chirp, sample count over global count, no padding needed
  '{32'h0000_0023, 32'h0000_0023, 64, 32'ha5a5_0001, 32'h5a5a_0002, 1'b0, 64},
  // waveform, upper adc, lower dac, 43 words padded
  '{32'h0000_0301, 32'h0000_0301, 60, 32'h0f0f_1111, 32'hf0f0_2222, 1'b0, 64},
  // waveform, source dropped to chirp mid record, latched only at the end
  '{32'h0000_0332, 32'h0000_0032, 150, 32'h3333_4444, 32'h5555_6666, 1'b0, 192},
  // source field 2'b10 is still chirp, switch to waveform mid record
  '{32'h0000_0201, 32'h0000_0301, 100, 32'h7777_8888, 32'h9999_aaaa, 1'b0, 128},
  // chirp with valid gaps
  '{32'h0000_0012, 32'h0000_0012, 90, 32'hbbbb_cccc, 32'hdddd_eeee, 1'b1, 0},
  // waveform with valid gaps, both counters routed
  '{32'h0000_0323, 32'h0000_0323, 80, 32'h0102_0304, 32'h0506_0708, 1'b1, 0},
  // chirp, upper route moves from global to sample count mid record
  '{32'h0000_0130, 32'h0000_0120, 129, 32'h1357_9bdf, 32'h2468_ace0, 1'b0, 192}
};

`endif

//--- verif/capture_tb.sv
`default_nettype none

module capture_tb;

  localparam int unsigned CHIRP_DELAY    = capture_pkg::DEF_CHIRP_DELAY;
  localparam int unsigned WFRM_DELAY     = capture_pkg::DEF_WFRM_DELAY;
  localparam int unsigned WFRM_DELAY_END = capture_pkg::DEF_WFRM_DELAY_END;
  localparam int unsigned ALIGN_WORDS    = capture_pkg::DEF_ALIGN_WORDS;
  localparam int unsigned CLK_PERIOD     = 100;
  localparam int unsigned RESET_CYCLES   = 8;
  // longest wait for the last word once the enable drops
  localparam int unsigned DRAIN_CYCLES   = 3 * ALIGN_WORDS + 40;

  `include "capture_tb_table.svh"

  logic                       clk_245_76MHz = 1'b0;
  logic                       cpu_reset;
  logic [31:0]                ctrl_word;
  logic                       chirp_init;
  logic                       chirp_enable;
  logic                       adc_enable;
  logic [31:0]                adc_iq;
  logic                       adc_valid;
  logic [31:0]                dac_iq;
  logic                       chirp_ready;
  logic                       chirp_done;
  logic                       chirp_active;
  logic                       wfrm_ready;
  logic                       wfrm_done;
  logic                       wfrm_active;
  logic                       chirp_init_o;
  logic                       chirp_enable_o;
  logic                       wfrm_init_o;
  logic                       wfrm_enable_o;
  logic                       ready_o;
  logic                       done_o;
  logic                       active_o;
  capture_pkg::capture_word_u cap_word;
  logic                       cap_valid_o;
  logic                       cap_first_o;
  logic                       cap_last_o;

  // reference model state, reset values
  logic                       m_en_d1 = 1'b0;
  logic                       m_active = 1'b0;
  logic                       m_first = 1'b0;
  logic                       m_wsel = 1'b0;
  int                         m_lat = 0;
  int                         m_align = 0;
  int                         m_word = 0;
  logic [31:0]                m_sample = '0;
  logic [31:0]                m_glbl = '0;
  logic [1:0]                 m_route_lo = capture_pkg::ROUTE_ADC;
  logic [1:0]                 m_route_hi = capture_pkg::ROUTE_ADC;
  logic                       exp_valid = 1'b0;
  logic                       exp_first = 1'b0;
  logic                       exp_last = 1'b0;
  capture_pkg::capture_word_u exp_word;

  // record scoreboard
  logic                       rec_open = 1'b0;
  logic                       rec_done = 1'b0;
  logic                       hdr_seen = 1'b0;
  int                         recs_closed = 0;
  int                         rec_words = 0;
  int                         prev_words = 0;
  logic [31:0]                rec_first_sample = '0;
  logic [31:0]                prev_sample = '0;
  logic [31:0]                prev_glbl = '0;

  int                         err_count = 0;
  int                         check_count = 0;
  logic [31:0]                lfsr_state;

  capture_top #(
    .CHIRP_DELAY    (CHIRP_DELAY),
    .WFRM_DELAY     (WFRM_DELAY),
    .WFRM_DELAY_END (WFRM_DELAY_END),
    .ALIGN_WORDS    (ALIGN_WORDS)
  ) dut (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .ctrl_word_i    (ctrl_word),
    .chirp_init_i   (chirp_init),
    .chirp_enable_i (chirp_enable),
    .adc_enable_i   (adc_enable),
    .adc_iq_i       (adc_iq),
    .adc_valid_i    (adc_valid),
    .dac_iq_i       (dac_iq),
    .chirp_ready_i  (chirp_ready),
    .chirp_done_i   (chirp_done),
    .chirp_active_i (chirp_active),
    .wfrm_ready_i   (wfrm_ready),
    .wfrm_done_i    (wfrm_done),
    .wfrm_active_i  (wfrm_active),
    .chirp_init_o   (chirp_init_o),
    .chirp_enable_o (chirp_enable_o),
    .wfrm_init_o    (wfrm_init_o),
    .wfrm_enable_o  (wfrm_enable_o),
    .ready_o        (ready_o),
    .done_o         (done_o),
    .active_o       (active_o),
    .cap_word_o     (cap_word),
    .cap_valid_o    (cap_valid_o),
    .cap_first_o    (cap_first_o),
    .cap_last_o     (cap_last_o)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk_245_76MHz = ~clk_245_76MHz;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic next_bit();
    logic feedback;
    feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], feedback};
    return feedback;
  endfunction

  function automatic logic [31:0] lane_source(input logic [1:0] route);
    case (route)
      capture_pkg::ROUTE_ADC:        return adc_iq;
      capture_pkg::ROUTE_DAC:        return dac_iq;
      capture_pkg::ROUTE_SAMPLE_CNT: return m_sample;
      default:                       return m_glbl;
    endcase
  endfunction

  // this cycle writes a header if the first or last strobe is due
  function automatic logic header_due();
    return m_first || ((m_lat == 0) && m_active && !m_en_d1 && (m_align == 0));
  endfunction

  // one clock edge of the capture rules, inputs as driven now
  task automatic advance_model();
    logic lat_zero;
    logic pending;
    logic wr_en;
    logic wr_last;
    logic start;
    logic pre_last;
    int   missing;
    lat_zero = (m_lat == 0);
    pending  = (m_align != 0);
    wr_en    = m_active && adc_valid;
    wr_last  = lat_zero && m_active && !m_en_d1 && !pending;
    start    = lat_zero && m_en_d1 && !m_active;
    pre_last = (m_lat == 1) && m_active && !m_en_d1;
    exp_valid = wr_en;
    exp_first = wr_en && m_first;
    exp_last  = wr_en && wr_last;
    if (wr_en && (m_first || wr_last)) begin
      exp_word.hdr.glbl_cnt   = m_glbl;
      exp_word.hdr.sample_cnt = m_sample;
    end else if (wr_en) begin
      exp_word.data.upper = lane_source(m_route_hi);
      exp_word.data.lower = lane_source(m_route_lo);
    end
    // start delay on init, end delay on the enable fall
    if (chirp_init) begin
      m_lat = m_wsel ? WFRM_DELAY : CHIRP_DELAY;
    end else if (m_en_d1 && !adc_enable) begin
      m_lat = m_wsel ? WFRM_DELAY_END : CHIRP_DELAY;
    end else if (!lat_zero) begin
      m_lat = m_lat - 1;
    end
    // pre-last word and last header still to come
    if (pre_last) begin
      missing = (m_word + 2) % ALIGN_WORDS;
      m_align = (missing == 0) ? 0 : ALIGN_WORDS - missing;
    end else if (pending) begin
      m_align = m_align - 1;
    end
    if (start) begin
      m_word = 0;
    end else if (wr_en) begin
      m_word = m_word + 1;
    end
    if (lat_zero && !pending) begin
      m_active = m_en_d1;
    end
    m_first = start;
    m_en_d1 = adc_enable;
    if (wr_en) begin
      m_sample = m_sample + 1;
    end
    m_glbl = m_glbl + 1;
    m_route_lo = ctrl_word[capture_pkg::ROUTE_LSB_LOWER +: capture_pkg::ROUTE_W];
    m_route_hi = ctrl_word[capture_pkg::ROUTE_LSB_UPPER +: capture_pkg::ROUTE_W];
    // choice frozen while the generator runs
    if (!chirp_enable) begin
      m_wsel = &ctrl_word[capture_pkg::SOURCE_LSB +: 2];
    end
  endtask

  // record properties, independent of the cycle model
  task automatic track_record();
    if (cap_first_o) begin
      compare_value("record open at first", 64'(rec_open), 64'(0));
      if (recs_closed > 0) begin
        // advance equals the whole previous record
        compare_value("header sample_cnt", 64'(cap_word.hdr.sample_cnt),
                      64'(prev_sample + prev_words));
      end
      rec_open         = 1'b1;
      rec_words        = 0;
      rec_first_sample = cap_word.hdr.sample_cnt;
    end else begin
      compare_value("record open", 64'(rec_open), 64'(1));
    end
    rec_words++;
    if (cap_first_o || cap_last_o) begin
      if (hdr_seen) begin
        compare_value("header glbl_cnt rising", 64'(cap_word.hdr.glbl_cnt > prev_glbl), 64'(1));
      end
      prev_glbl = cap_word.hdr.glbl_cnt;
      hdr_seen  = 1'b1;
    end
    if (cap_last_o) begin
      rec_open    = 1'b0;
      rec_done    = 1'b1;
      prev_sample = rec_first_sample;
      prev_words  = rec_words;
      recs_closed++;
    end
  endtask

  task automatic check_outputs();
    // steering against the latched choice
    compare_value("chirp_init_o", 64'(chirp_init_o), 64'(chirp_init && !m_wsel));
    compare_value("chirp_enable_o", 64'(chirp_enable_o), 64'(chirp_enable && !m_wsel));
    compare_value("wfrm_init_o", 64'(wfrm_init_o), 64'(chirp_init && m_wsel));
    compare_value("wfrm_enable_o", 64'(wfrm_enable_o), 64'(chirp_enable && m_wsel));
    compare_value("ready_o", 64'(ready_o), 64'(m_wsel ? wfrm_ready : chirp_ready));
    compare_value("done_o", 64'(done_o), 64'(m_wsel ? wfrm_done : chirp_done));
    compare_value("active_o", 64'(active_o), 64'(m_wsel ? wfrm_active : chirp_active));
    compare_value("cap_valid_o", 64'(cap_valid_o), 64'(exp_valid));
    compare_value("cap_first_o", 64'(cap_first_o), 64'(exp_first));
    compare_value("cap_last_o", 64'(cap_last_o), 64'(exp_last));
    if (exp_valid) begin
      compare_value("cap_word_o", cap_word, exp_word);
    end
    if (cap_valid_o) begin
      track_record();
    end
  endtask

  // one clock, ends on the next falling edge after the check
  task automatic step_cycle(input logic gaps);
    chirp_ready  = next_bit();
    chirp_done   = next_bit();
    chirp_active = next_bit();
    wfrm_ready   = next_bit();
    wfrm_done    = next_bit();
    wfrm_active  = next_bit();
    // headers always written, gaps only on data
    if (gaps && !header_due()) begin
      adc_valid = next_bit();
    end else begin
      adc_valid = 1'b1;
    end
    advance_model();
    @(negedge clk_245_76MHz);
    check_outputs();
  endtask

  ////////////////////////////////////////////////////////////
  // record sequence
  ////////////////////////////////////////////////////////////

  task automatic run_record(input int r);
    int n;
    int waited;
    ctrl_word = RECS[r].ctrl;
    adc_iq    = RECS[r].adc_iq;
    dac_iq    = RECS[r].dac_iq;
    rec_done  = 1'b0;
    // let the source choice latch while idle
    repeat (2) step_cycle(RECS[r].gaps);
    chirp_init   = 1'b1;
    chirp_enable = 1'b1;
    adc_enable   = 1'b1;
    step_cycle(RECS[r].gaps);
    chirp_init = 1'b0;
    for (n = 1; n < RECS[r].cycles; n++) begin
      if (n == RECS[r].cycles / 2) begin
        ctrl_word = RECS[r].ctrl_mid;
      end
      step_cycle(RECS[r].gaps);
    end
    chirp_enable = 1'b0;
    adc_enable   = 1'b0;
    waited = 0;
    while (!rec_done && waited < DRAIN_CYCLES) begin
      step_cycle(RECS[r].gaps);
      waited++;
    end
    if (!rec_done) begin
      err_count++;
      $display("record %0d produced no last word within %0d cycles", r, DRAIN_CYCLES);
    end else if (RECS[r].exp_words != 0) begin
      compare_value("record words", 64'(rec_words), 64'(RECS[r].exp_words));
      compare_value("record words mod align", 64'(rec_words % ALIGN_WORDS), 64'(0));
    end
  endtask

  function automatic int unsigned watchdog_cycles();
    int unsigned total;
    int          r;
    total = RESET_CYCLES + 20;
    for (r = 0; r < NUM_RECS; r++) begin
      // idle, enable window, generator delay, padding and drain
      total += RECS[r].cycles + WFRM_DELAY + DRAIN_CYCLES + 4;
    end
    return total;
  endfunction

  initial begin
    #(CLK_PERIOD * watchdog_cycles());
    $display("watchdog expired before all records finished");
    $display("test failed");
    $finish;
  end

  initial begin
    int r;
    lfsr_state   = 32'h06ea_6269;
    cpu_reset    = 1'b1;
    ctrl_word    = '0;
    chirp_init   = 1'b0;
    chirp_enable = 1'b0;
    adc_enable   = 1'b0;
    adc_iq       = '0;
    adc_valid    = 1'b0;
    dac_iq       = '0;
    chirp_ready  = 1'b0;
    chirp_done   = 1'b0;
    chirp_active = 1'b0;
    wfrm_ready   = 1'b0;
    wfrm_done    = 1'b0;
    wfrm_active  = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_245_76MHz);
    cpu_reset = 1'b0;
    // quiet outputs straight out of reset
    compare_value("cap_valid_o", 64'(cap_valid_o), 64'(0));
    compare_value("cap_first_o", 64'(cap_first_o), 64'(0));
    compare_value("cap_last_o", 64'(cap_last_o), 64'(0));
    compare_value("chirp_init_o", 64'(chirp_init_o), 64'(0));
    compare_value("chirp_enable_o", 64'(chirp_enable_o), 64'(0));
    compare_value("wfrm_init_o", 64'(wfrm_init_o), 64'(0));
    compare_value("wfrm_enable_o", 64'(wfrm_enable_o), 64'(0));
    for (r = 0; r < NUM_RECS; r++) begin
      run_record(r);
    end
    repeat (4) step_cycle(1'b0);
    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/capture_top.sv
`default_nettype none

module capture_top #(
  parameter int unsigned CHIRP_DELAY    = capture_pkg::DEF_CHIRP_DELAY,
  parameter int unsigned WFRM_DELAY     = capture_pkg::DEF_WFRM_DELAY,
  parameter int unsigned WFRM_DELAY_END = capture_pkg::DEF_WFRM_DELAY_END,
  parameter int unsigned ALIGN_WORDS    = capture_pkg::DEF_ALIGN_WORDS
) (
  input  wire                            clk_245_76MHz,
  input  wire                            cpu_reset,
  // control
  input  wire [capture_pkg::CTRL_W-1:0] ctrl_word_i,
  input  wire                            chirp_init_i,
  input  wire                            chirp_enable_i,
  input  wire                            adc_enable_i,
  // sample streams
  input  wire [capture_pkg::IQ_W-1:0]   adc_iq_i,
  input  wire                            adc_valid_i,
  input  wire [capture_pkg::IQ_W-1:0]   dac_iq_i,
  // generator status
  input  wire                            chirp_ready_i,
  input  wire                            chirp_done_i,
  input  wire                            chirp_active_i,
  input  wire                            wfrm_ready_i,
  input  wire                            wfrm_done_i,
  input  wire                            wfrm_active_i,
  // gated generator controls
  output logic                           chirp_init_o,
  output logic                           chirp_enable_o,
  output logic                           wfrm_init_o,
  output logic                           wfrm_enable_o,
  // merged status
  output logic                           ready_o,
  output logic                           done_o,
  output logic                           active_o,
  // capture stream
  output capture_pkg::capture_word_u     cap_word_o,
  output logic                           cap_valid_o,
  output logic                           cap_first_o,
  output logic                           cap_last_o
);

  logic                          wfrm_select;
  logic                          wr_en;
  logic                          wr_first;
  logic                          wr_last;
  logic [capture_pkg::CNT_W-1:0] sample_cnt;
  logic [capture_pkg::CNT_W-1:0] glbl_cnt;
  // lane 0 lower half, lane 1 upper half
  logic [capture_pkg::IQ_W-1:0]  lane_word [2];

  source_arbiter u_source_arbiter (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .ctrl_word_i    (ctrl_word_i),
    .chirp_init_i   (chirp_init_i),
    .chirp_enable_i (chirp_enable_i),
    .chirp_ready_i  (chirp_ready_i),
    .chirp_done_i   (chirp_done_i),
    .chirp_active_i (chirp_active_i),
    .wfrm_ready_i   (wfrm_ready_i),
    .wfrm_done_i    (wfrm_done_i),
    .wfrm_active_i  (wfrm_active_i),
    .chirp_init_o   (chirp_init_o),
    .chirp_enable_o (chirp_enable_o),
    .wfrm_init_o    (wfrm_init_o),
    .wfrm_enable_o  (wfrm_enable_o),
    .ready_o        (ready_o),
    .done_o         (done_o),
    .active_o       (active_o),
    .wfrm_select_o  (wfrm_select)
  );

  capture_sequencer #(
    .CHIRP_DELAY    (CHIRP_DELAY),
    .WFRM_DELAY     (WFRM_DELAY),
    .WFRM_DELAY_END (WFRM_DELAY_END),
    .ALIGN_WORDS    (ALIGN_WORDS)
  ) u_capture_sequencer (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .chirp_init_i  (chirp_init_i),
    .adc_enable_i  (adc_enable_i),
    .adc_valid_i   (adc_valid_i),
    .wfrm_select_i (wfrm_select),
    .wr_en_o       (wr_en),
    .wr_first_o    (wr_first),
    .wr_last_o     (wr_last),
    .sample_cnt_o  (sample_cnt),
    .glbl_cnt_o    (glbl_cnt)
  );

  ////////////////////////////////////////////////////////////
  // route lanes
  ////////////////////////////////////////////////////////////

  for (genvar lane = 0; lane < 2; lane++) begin : g_lane
    route_lane #(
      .ROUTE_LSB ((lane == 0) ? capture_pkg::ROUTE_LSB_LOWER
                              : capture_pkg::ROUTE_LSB_UPPER)
    ) u_route_lane (
      .clk_245_76MHz (clk_245_76MHz),
      .cpu_reset     (cpu_reset),
      .ctrl_word_i   (ctrl_word_i),
      .adc_iq_i      (adc_iq_i),
      .dac_iq_i      (dac_iq_i),
      .sample_cnt_i  (sample_cnt),
      .glbl_cnt_i    (glbl_cnt),
      .lane_word_o   (lane_word[lane])
    );
  end

  frame_assembler u_frame_assembler (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .wr_en_i       (wr_en),
    .wr_first_i    (wr_first),
    .wr_last_i     (wr_last),
    .sample_cnt_i  (sample_cnt),
    .glbl_cnt_i    (glbl_cnt),
    .upper_word_i  (lane_word[1]),
    .lower_word_i  (lane_word[0]),
    .cap_word_o    (cap_word_o),
    .cap_valid_o   (cap_valid_o),
    .cap_first_o   (cap_first_o),
    .cap_last_o    (cap_last_o)
  );

endmodule

`default_nettype wire

//--- hdl/frame_assembler.sv
`default_nettype none

module frame_assembler (
  input  wire                                 clk_245_76MHz,
  input  wire                                 cpu_reset,
  input  wire                                 wr_en_i,
  input  wire                                 wr_first_i,
  input  wire                                 wr_last_i,
  input  wire  [capture_pkg::CNT_W-1:0]       sample_cnt_i,
  input  wire  [capture_pkg::CNT_W-1:0]       glbl_cnt_i,
  input  wire  [capture_pkg::IQ_W-1:0]        upper_word_i,
  input  wire  [capture_pkg::IQ_W-1:0]        lower_word_i,
  output capture_pkg::capture_word_u          cap_word_o,
  output logic                                cap_valid_o,
  output logic                                cap_first_o,
  output logic                                cap_last_o
);

  capture_pkg::capture_word_u word_next;

  // header at both record ends, lane data in between
  always_comb begin
    if (wr_first_i || wr_last_i) begin
      word_next.hdr.glbl_cnt   = glbl_cnt_i;
      word_next.hdr.sample_cnt = sample_cnt_i;
    end else begin
      word_next.data.upper = upper_word_i;
      word_next.data.lower = lower_word_i;
    end
  end

  // payload only loads on a write
  always_ff @(posedge clk_245_76MHz) begin
    if (wr_en_i) begin
      cap_word_o <= word_next;
    end
  end

  // strobes one clock after wr_en, markers only on real writes
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      cap_valid_o <= 1'b0;
      cap_first_o <= 1'b0;
      cap_last_o  <= 1'b0;
    end else begin
      cap_valid_o <= wr_en_i;
      cap_first_o <= wr_en_i & wr_first_i;
      cap_last_o  <= wr_en_i & wr_last_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/route_lane.sv
`default_nettype none

module route_lane #(
  // bit position of this lane's route field
  parameter int unsigned ROUTE_LSB = capture_pkg::ROUTE_LSB_LOWER
) (
  input  wire                             clk_245_76MHz,
  input  wire                             cpu_reset,
  input  wire  [capture_pkg::CTRL_W-1:0]  ctrl_word_i,
  input  wire  [capture_pkg::IQ_W-1:0]    adc_iq_i,
  input  wire  [capture_pkg::IQ_W-1:0]    dac_iq_i,
  input  wire  [capture_pkg::CNT_W-1:0]   sample_cnt_i,
  input  wire  [capture_pkg::CNT_W-1:0]   glbl_cnt_i,
  output logic [capture_pkg::IQ_W-1:0]    lane_word_o
);

  logic [capture_pkg::ROUTE_W-1:0] route_q;

  // route change shows one clock later
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      route_q <= capture_pkg::ROUTE_ADC;
    end else begin
      route_q <= ctrl_word_i[ROUTE_LSB +: capture_pkg::ROUTE_W];
    end
  end

  // four way source select
  always_comb begin
    case (route_q)
      capture_pkg::ROUTE_ADC: begin
        lane_word_o = adc_iq_i;
      end
      capture_pkg::ROUTE_DAC: begin
        lane_word_o = dac_iq_i;
      end
      capture_pkg::ROUTE_SAMPLE_CNT: begin
        lane_word_o = sample_cnt_i;
      end
      default: begin
        // ROUTE_GLBL_CNT
        lane_word_o = glbl_cnt_i;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/capture_sequencer.sv
`default_nettype none

module capture_sequencer #(
  parameter int unsigned CHIRP_DELAY    = capture_pkg::DEF_CHIRP_DELAY,
  parameter int unsigned WFRM_DELAY     = capture_pkg::DEF_WFRM_DELAY,
  parameter int unsigned WFRM_DELAY_END = capture_pkg::DEF_WFRM_DELAY_END,
  parameter int unsigned ALIGN_WORDS    = capture_pkg::DEF_ALIGN_WORDS
) (
  input  wire                           clk_245_76MHz,
  input  wire                           cpu_reset,
  input  wire                           chirp_init_i,
  input  wire                           adc_enable_i,
  input  wire                           adc_valid_i,
  input  wire                           wfrm_select_i,
  output logic                          wr_en_o,
  output logic                          wr_first_o,
  output logic                          wr_last_o,
  output logic [capture_pkg::CNT_W-1:0] sample_cnt_o,
  output logic [capture_pkg::CNT_W-1:0] glbl_cnt_o
);

  // word and alignment counters wrap at ALIGN_WORDS
  localparam int unsigned AW = (ALIGN_WORDS > 1) ? $clog2(ALIGN_WORDS) : 1;

  logic                          adc_en_d1;
  logic                          capture_active;
  logic [capture_pkg::LAT_W-1:0] lat_cnt;
  logic [capture_pkg::LAT_W-1:0] start_delay;
  logic [capture_pkg::LAT_W-1:0] end_delay;
  logic [AW-1:0]                 word_cnt;
  logic [AW-1:0]                 align_cnt;
  logic                          lat_zero;
  logic                          align_pending;
  logic                          enable_fall;
  logic                          start;
  logic                          pre_last;

  ////////////////////////////////////////////////////////////
  // enable delay and generator latency
  ////////////////////////////////////////////////////////////

  // waveform player has a longer pipe at start, shorter at end
  assign start_delay = wfrm_select_i ? capture_pkg::LAT_W'(WFRM_DELAY)
                                     : capture_pkg::LAT_W'(CHIRP_DELAY);
  assign end_delay   = wfrm_select_i ? capture_pkg::LAT_W'(WFRM_DELAY_END)
                                     : capture_pkg::LAT_W'(CHIRP_DELAY);

  assign lat_zero      = (lat_cnt == '0);
  assign align_pending = |align_cnt;
  // delayed enable high, raw enable already low
  assign enable_fall   = adc_en_d1 & ~adc_enable_i;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      adc_en_d1 <= 1'b0;
    end else begin
      adc_en_d1 <= adc_enable_i;
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      lat_cnt <= '0;
    end else if (chirp_init_i) begin
      lat_cnt <= start_delay;
    end else if (enable_fall) begin
      lat_cnt <= end_delay;
    end else if (!lat_zero) begin
      lat_cnt <= lat_cnt - 1'b1;
    end
  end

  // capture window follows the delayed enable once the generator pipe
  // has drained and no padding is still owed
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      capture_active <= 1'b0;
    end else if (lat_zero && !align_pending) begin
      capture_active <= adc_en_d1;
    end
  end

  ////////////////////////////////////////////////////////////
  // record framing
  ////////////////////////////////////////////////////////////

  assign start    = lat_zero & adc_en_d1 & ~capture_active;
  // one clock ahead of the earliest possible last word
  assign pre_last = (lat_cnt == capture_pkg::LAT_W'(1)) & capture_active & ~adc_en_d1;

  assign wr_en_o   = capture_active & adc_valid_i;
  assign wr_last_o = lat_zero & capture_active & ~adc_en_d1 & ~align_pending;

  // words written so far in this record, modulo the block size
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      word_cnt <= '0;
    end else if (start) begin
      word_cnt <= '0;
    end else if (wr_en_o) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  // pre_last word plus the last header still follow word_cnt,
  // so pad by -(word_cnt + 2) mod ALIGN_WORDS
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      align_cnt <= '0;
    end else if (pre_last) begin
      align_cnt <= AW'(0) - (word_cnt + AW'(2));
    end else if (align_pending) begin
      align_cnt <= align_cnt - 1'b1;
    end
  end

  // first header lands one clock after the start
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_first_o <= 1'b0;
    end else begin
      wr_first_o <= start;
    end
  end

  ////////////////////////////////////////////////////////////
  // free running counters
  ////////////////////////////////////////////////////////////

  // sample count keeps running across records
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      sample_cnt_o <= '0;
    end else if (wr_en_o) begin
      sample_cnt_o <= sample_cnt_o + 1'b1;
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      glbl_cnt_o <= '0;
    end else begin
      glbl_cnt_o <= glbl_cnt_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/source_arbiter.sv
`default_nettype none

module source_arbiter (
  input  wire                            clk_245_76MHz,
  input  wire                            cpu_reset,
  input  wire [capture_pkg::CTRL_W-1:0] ctrl_word_i,
  input  wire                            chirp_init_i,
  input  wire                            chirp_enable_i,
  // status from the chirp dds
  input  wire                            chirp_ready_i,
  input  wire                            chirp_done_i,
  input  wire                            chirp_active_i,
  // status from the waveform player
  input  wire                            wfrm_ready_i,
  input  wire                            wfrm_done_i,
  input  wire                            wfrm_active_i,
  output logic                           chirp_init_o,
  output logic                           chirp_enable_o,
  output logic                           wfrm_init_o,
  output logic                           wfrm_enable_o,
  output logic                           ready_o,
  output logic                           done_o,
  output logic                           active_o,
  output logic                           wfrm_select_o
);

  logic [1:0] src_field_q;

  // source field only follows the control word while the chirp is off
  // so a running generator is never swapped underneath
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      // chirp dds after reset
      src_field_q <= 2'b00;
    end else if (!chirp_enable_i) begin
      src_field_q <= ctrl_word_i[capture_pkg::SOURCE_LSB +: 2];
    end
  end

  // waveform player only on 2'b11
  assign wfrm_select_o = &src_field_q;

  // init and enable steered to the chosen generator
  assign chirp_init_o   = chirp_init_i   & ~wfrm_select_o;
  assign chirp_enable_o = chirp_enable_i & ~wfrm_select_o;
  assign wfrm_init_o    = chirp_init_i   &  wfrm_select_o;
  assign wfrm_enable_o  = chirp_enable_i &  wfrm_select_o;

  // status back from the chosen generator
  assign ready_o  = wfrm_select_o ? wfrm_ready_i  : chirp_ready_i;
  assign done_o   = wfrm_select_o ? wfrm_done_i   : chirp_done_i;
  assign active_o = wfrm_select_o ? wfrm_active_i : chirp_active_i;

endmodule

`default_nettype wire

//--- hdl/capture_pkg.sv
`default_nettype none

package capture_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // one packed iq sample, 16 bit i above 16 bit q
  localparam int unsigned IQ_W    = 32;
  localparam int unsigned CTRL_W  = 32;
  localparam int unsigned CNT_W   = 32;
  localparam int unsigned WORD_W  = 64;
  localparam int unsigned ROUTE_W = 2;
  localparam int unsigned LAT_W   = 8;

  ////////////////////////////////////////////////////////////
  // control word fields
  ////////////////////////////////////////////////////////////

  // route codes for both lanes
  localparam logic [ROUTE_W-1:0] ROUTE_ADC        = 2'd0;
  localparam logic [ROUTE_W-1:0] ROUTE_DAC        = 2'd1;
  localparam logic [ROUTE_W-1:0] ROUTE_SAMPLE_CNT = 2'd2;
  localparam logic [ROUTE_W-1:0] ROUTE_GLBL_CNT   = 2'd3;

  localparam int unsigned ROUTE_LSB_LOWER = 0;
  localparam int unsigned ROUTE_LSB_UPPER = 4;
  // 2 bit source field, waveform player when both bits set
  localparam int unsigned SOURCE_LSB      = 8;

  // generator latency defaults, in clocks
  localparam int unsigned DEF_CHIRP_DELAY    = 3;
  localparam int unsigned DEF_WFRM_DELAY     = 19;
  localparam int unsigned DEF_WFRM_DELAY_END = 2;
  // record padding, power of two
  localparam int unsigned DEF_ALIGN_WORDS    = 64;

  // capture word, header or data view of the same 64 bits
  typedef union packed {
    struct packed {
      logic [CNT_W-1:0] glbl_cnt;
      logic [CNT_W-1:0] sample_cnt;
    } hdr;
    struct packed {
      logic [IQ_W-1:0] upper;
      logic [IQ_W-1:0] lower;
    } data;
  } capture_word_u;

endpackage

`default_nettype wire
